/* hw/icache_cfg_pkg.sv */
// instruction cache store geometry
// four ways of 64 sets, each set holding one 64-bit line per way

`default_nettype none

package icache_cfg_pkg;

  localparam int ways = 4;
  localparam int sets = 64;

  // address split is tag, set index, byte offset
  localparam int index_width = 6;
  localparam int offset_width = 3;
  localparam int addr_width = 32;
  localparam int tag_width = addr_width - index_width - offset_width;

  localparam int line_width = 64;

endpackage

`default_nettype wire

/* hw/icache_types_pkg.sv */
// instruction cache store payload types
// tag RAM entries, lines and per-way masks

`default_nettype none

package icache_types_pkg;

  import icache_cfg_pkg::*;

  typedef logic [tag_width-1:0] tag_t;
  typedef logic [index_width-1:0] index_t;
  typedef logic [line_width-1:0] line_t;

  // hits, victim select and nru clear masks
  typedef logic [ways-1:0] way_mask_t;

  // one word of the tag RAM
  typedef struct packed {
    logic valid;
    logic nru;
    tag_t tag;
  } tag_entry_t;

endpackage

`default_nettype wire

/* hw/ic_ram.sv */
// per-way cache RAM
// one write port, read through a registered address

`timescale 1ns/100ps
`default_nettype none

module ic_ram
  import icache_cfg_pkg::*;
  import icache_types_pkg::*;
#(
  parameter type payload_t = line_t
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     rd_en,
  input  index_t   rd_addr,
  output payload_t rd_data,
  input  logic     wr_en,
  input  index_t   wr_addr,
  input  payload_t wr_data
);

  payload_t mem [sets];
  index_t rd_addr_q;

  // array read is combinational, so a write shows on the next cycle
  assign rd_data = mem[rd_addr_q];

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr_q <= '0;
    end else if (rd_en) begin
      rd_addr_q <= rd_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

endmodule

`default_nettype wire

/* hw/ic_req_stage.sv */
// cache request stage
// takes lookups and fills, sequences fills, sweeps the tags clear
// after reset or invalidate and broadcasts index and tag to the ways

`timescale 1ns/100ps
`default_nettype none

module ic_req_stage
  import icache_cfg_pkg::*;
  import icache_types_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  lookup_valid,
  input  logic [addr_width-1:0] lookup_addr,
  output logic                  lookup_ready,
  input  logic                  fill_valid,
  input  logic [addr_width-1:0] fill_addr,
  input  line_t                 fill_data,
  output logic                  fill_ready,
  input  logic                  invalidate,
  output logic                  rd_en,
  output index_t                rd_index,
  output tag_t                  cmp_tag,
  output logic                  cmp_en,
  output logic                  fill_phase,
  output logic                  commit,
  output line_t                 wr_line,
  output tag_t                  wr_tag,
  output logic                  clear_en,
  output index_t                clear_index
);

  typedef enum logic [1:0] {
    fill_idle,
    fill_read,
    fill_cmp,
    fill_commit
  } fill_state_t;

  fill_state_t fill_state;
  logic clearing;
  index_t clear_count;
  logic lookup_q;
  tag_t req_tag_q;
  index_t req_index_q;
  line_t fill_line_q;
  logic accept_ok;
  logic fill_take;
  logic lookup_take;

  // nothing new while sweeping or while a fill is in flight
  assign accept_ok = ~clearing & (fill_state == fill_idle) & ~invalidate;
  assign fill_ready = accept_ok;
  // fills win when both are offered
  assign lookup_ready = accept_ok & ~fill_valid;
  assign fill_take = fill_valid & fill_ready;
  assign lookup_take = lookup_valid & lookup_ready;

  // clearing sweep, one set per cycle
  always_ff @(posedge clk) begin
    if (rst || invalidate) begin
      clearing <= 1'b1;
      clear_count <= '0;
    end else if (clearing) begin
      clear_count <= clear_count + 1'b1;
      if (clear_count == index_t'(sets - 1)) begin
        clearing <= 1'b0;
      end
    end
  end

  assign clear_en = clearing;
  assign clear_index = clear_count;

  always_ff @(posedge clk) begin
    if (rst || invalidate) begin
      fill_state <= fill_idle;
    end else begin
      case (fill_state)
        fill_idle: begin
          if (fill_take) begin
            fill_state <= fill_read;
          end
        end
        fill_read: fill_state <= fill_cmp;
        fill_cmp: fill_state <= fill_commit;
        default: fill_state <= fill_idle;
      endcase
    end
  end

  // accepted lookup, then its compare slot one cycle later
  always_ff @(posedge clk) begin
    if (rst) begin
      lookup_q <= 1'b0;
      cmp_en <= 1'b0;
    end else begin
      lookup_q <= lookup_take;
      cmp_en <= lookup_q;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_take) begin
      req_tag_q <= fill_addr[addr_width-1 -: tag_width];
      req_index_q <= fill_addr[offset_width +: index_width];
      fill_line_q <= fill_data;
    end else if (lookup_take) begin
      req_tag_q <= lookup_addr[addr_width-1 -: tag_width];
      req_index_q <= lookup_addr[offset_width +: index_width];
    end
    // tag lines up with the RAM output
    if (rd_en) begin
      cmp_tag <= req_tag_q;
    end
  end

  assign rd_en = lookup_q | (fill_state == fill_read);
  assign rd_index = req_index_q;
  assign fill_phase = (fill_state == fill_cmp);
  assign commit = (fill_state == fill_commit);
  assign wr_tag = req_tag_q;
  assign wr_line = fill_line_q;

endmodule

`default_nettype wire

/* hw/ic_way.sv */
// one cache way
// tag and data RAMs, tag compare and nru write-back

`timescale 1ns/100ps
`default_nettype none

module ic_way
  import icache_types_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   rd_en,
  input  index_t rd_index,
  input  tag_t   cmp_tag,
  input  logic   cmp_en,
  input  logic   fill_phase,
  input  logic   commit,
  input  line_t  wr_line,
  input  tag_t   wr_tag,
  input  logic   clear_en,
  input  index_t clear_index,
  input  logic   victim_sel,
  input  logic   nru_clear,
  output logic   way_hit,
  output logic   way_valid,
  output logic   way_nru,
  output tag_t   way_tag,
  output line_t  way_data
);

  tag_entry_t rd_entry;
  tag_entry_t wr_entry;
  logic tag_wr_en;
  index_t tag_wr_addr;
  logic data_wr_en;
  index_t idx_q;
  logic tag_match;

  // set of the last read, the target of any write-back
  always_ff @(posedge clk) begin
    if (rst) begin
      idx_q <= '0;
    end else if (rd_en) begin
      idx_q <= rd_index;
    end
  end

  assign tag_match = rd_entry.valid & (rd_entry.tag == cmp_tag);
  assign way_hit = (cmp_en | fill_phase) & tag_match;
  assign way_valid = rd_entry.valid;
  assign way_nru = rd_entry.nru;
  assign way_tag = rd_entry.tag;

  // sweep beats any other tag write
  always_comb begin
    tag_wr_en = 1'b0;
    tag_wr_addr = idx_q;
    wr_entry = rd_entry;
    if (clear_en) begin
      tag_wr_en = 1'b1;
      tag_wr_addr = clear_index;
      wr_entry = '0;
    end else if (commit && victim_sel) begin
      tag_wr_en = 1'b1;
      wr_entry = '{valid: 1'b1, nru: 1'b1, tag: wr_tag};
    end else if (commit && nru_clear) begin
      tag_wr_en = 1'b1;
      wr_entry.nru = 1'b0;
    end else if (cmp_en && way_hit && !rd_entry.nru) begin
      tag_wr_en = 1'b1;
      wr_entry.nru = 1'b1;
    end
  end

  assign data_wr_en = commit & victim_sel & ~clear_en;

  ic_ram #(.payload_t(tag_entry_t)) i_tag_ram (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (rd_en),
    .rd_addr (rd_index),
    .rd_data (rd_entry),
    .wr_en   (tag_wr_en),
    .wr_addr (tag_wr_addr),
    .wr_data (wr_entry)
  );

  ic_ram #(.payload_t(line_t)) i_data_ram (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (rd_en),
    .rd_addr (rd_index),
    .rd_data (way_data),
    .wr_en   (data_wr_en),
    .wr_addr (idx_q),
    .wr_data (wr_line)
  );

endmodule

`default_nettype wire

/* hw/ic_way_merge.sv */
// way merge
// folds per-way hits into one response, picks the nru victim
// for fills and reports the line it evicts

`timescale 1ns/100ps
`default_nettype none

module ic_way_merge
  import icache_cfg_pkg::*;
  import icache_types_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cmp_en,
  input  logic                  fill_phase,
  input  logic                  commit,
  input  way_mask_t             way_hit,
  input  way_mask_t             way_valid,
  input  way_mask_t             way_nru,
  input  tag_t                  way_tag [ways],
  input  line_t                 way_data [ways],
  input  index_t                rd_index,
  output logic                  resp_valid,
  output logic                  resp_hit,
  output line_t                 resp_data,
  output way_mask_t             victim_sel,
  output way_mask_t             nru_clear,
  output logic                  evict_valid,
  output logic [addr_width-1:0] evict_addr
);

  line_t hit_data;
  way_mask_t victim_next;
  way_mask_t nru_clear_next;
  logic evict_next;
  tag_t victim_tag;
  logic evict_pend;

  // at most one way hits
  always_comb begin
    hit_data = '0;
    for (int w = 0; w < ways; w++) begin
      hit_data |= way_data[w] & {line_width{way_hit[w]}};
    end
  end

  always_comb begin
    victim_next = '0;
    nru_clear_next = '0;
    evict_next = 1'b0;
    victim_tag = way_tag[0];
    if (|way_hit) begin
      // resident tag, rewrite in place
      victim_next = way_hit;
    end else if (!(&way_valid)) begin
      for (int w = ways - 1; w >= 0; w--) begin
        if (!way_valid[w]) begin
          victim_next = way_mask_t'(1) << w;
        end
      end
    end else if (!(&way_nru)) begin
      for (int w = ways - 1; w >= 0; w--) begin
        if (!way_nru[w]) begin
          victim_next = way_mask_t'(1) << w;
        end
      end
      evict_next = 1'b1;
    end else begin
      // every way recently used, take way 0 and age the rest
      victim_next = way_mask_t'(1);
      nru_clear_next = ~way_mask_t'(1);
      evict_next = 1'b1;
    end
    for (int w = 0; w < ways; w++) begin
      if (victim_next[w]) begin
        victim_tag = way_tag[w];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid <= 1'b0;
      victim_sel <= '0;
      nru_clear <= '0;
      evict_pend <= 1'b0;
      evict_valid <= 1'b0;
    end else begin
      resp_valid <= cmp_en;
      evict_valid <= commit & evict_pend;
      if (fill_phase) begin
        victim_sel <= victim_next;
        nru_clear <= nru_clear_next;
        evict_pend <= evict_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmp_en) begin
      resp_hit <= |way_hit;
      resp_data <= hit_data;
    end
    if (fill_phase) begin
      evict_addr <= {victim_tag, rd_index, {offset_width{1'b0}}};
    end
  end

endmodule

`default_nettype wire

/* hw/icache_store.sv */
// instruction cache tag and data store
// request stage feeding four identical ways, whose results are
// folded by the merge into a lookup response and fill eviction

`timescale 1ns/100ps
`default_nettype none

module icache_store
  import icache_cfg_pkg::*;
  import icache_types_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  lookup_valid,
  input  logic [addr_width-1:0] lookup_addr,
  output logic                  lookup_ready,
  output logic                  resp_valid,
  output logic                  resp_hit,
  output line_t                 resp_data,
  input  logic                  fill_valid,
  input  logic [addr_width-1:0] fill_addr,
  input  line_t                 fill_data,
  output logic                  fill_ready,
  output logic                  evict_valid,
  output logic [addr_width-1:0] evict_addr,
  input  logic                  invalidate
);

  logic rd_en;
  index_t rd_index;
  tag_t cmp_tag;
  logic cmp_en;
  logic fill_phase;
  logic commit;
  line_t wr_line;
  tag_t wr_tag;
  logic clear_en;
  index_t clear_index;

  way_mask_t way_hit;
  way_mask_t way_valid;
  way_mask_t way_nru;
  tag_t way_tag [ways];
  line_t way_data [ways];
  way_mask_t victim_sel;
  way_mask_t nru_clear;

  ic_req_stage i_req_stage (
    .clk          (clk),
    .rst          (rst),
    .lookup_valid (lookup_valid),
    .lookup_addr  (lookup_addr),
    .lookup_ready (lookup_ready),
    .fill_valid   (fill_valid),
    .fill_addr    (fill_addr),
    .fill_data    (fill_data),
    .fill_ready   (fill_ready),
    .invalidate   (invalidate),
    .rd_en        (rd_en),
    .rd_index     (rd_index),
    .cmp_tag      (cmp_tag),
    .cmp_en       (cmp_en),
    .fill_phase   (fill_phase),
    .commit       (commit),
    .wr_line      (wr_line),
    .wr_tag       (wr_tag),
    .clear_en     (clear_en),
    .clear_index  (clear_index)
  );

  generate
    for (genvar w = 0; w < ways; w++) begin : way_gen
      ic_way i_way (
        .clk         (clk),
        .rst         (rst),
        .rd_en       (rd_en),
        .rd_index    (rd_index),
        .cmp_tag     (cmp_tag),
        .cmp_en      (cmp_en),
        .fill_phase  (fill_phase),
        .commit      (commit),
        .wr_line     (wr_line),
        .wr_tag      (wr_tag),
        .clear_en    (clear_en),
        .clear_index (clear_index),
        .victim_sel  (victim_sel[w]),
        .nru_clear   (nru_clear[w]),
        .way_hit     (way_hit[w]),
        .way_valid   (way_valid[w]),
        .way_nru     (way_nru[w]),
        .way_tag     (way_tag[w]),
        .way_data    (way_data[w])
      );
    end
  endgenerate

  ic_way_merge i_way_merge (
    .clk         (clk),
    .rst         (rst),
    .cmp_en      (cmp_en),
    .fill_phase  (fill_phase),
    .commit      (commit),
    .way_hit     (way_hit),
    .way_valid   (way_valid),
    .way_nru     (way_nru),
    .way_tag     (way_tag),
    .way_data    (way_data),
    .rd_index    (rd_index),
    .resp_valid  (resp_valid),
    .resp_hit    (resp_hit),
    .resp_data   (resp_data),
    .victim_sel  (victim_sel),
    .nru_clear   (nru_clear),
    .evict_valid (evict_valid),
    .evict_addr  (evict_addr)
  );

endmodule

`default_nettype wire

/* testbench/icache_store_tb.sv */
// instruction cache store testbench
// directed tests checked against a model of tags, lines and nru bits

`timescale 1ns/100ps
`default_nettype none

module icache_store_tb
  import icache_cfg_pkg::*;
  import icache_types_pkg::*;
();

  localparam int accept_limit = sets + 8;
  localparam int resp_limit = 8;
  localparam int fill_limit = 8;
  // rough worst case per operation in cycles
  localparam int lookup_cost = accept_limit + resp_limit;
  localparam int fill_cost = accept_limit + fill_limit;
  localparam int watchdog_cycles = 10 + 3 * (sets + 8) + 120 * lookup_cost
                                   + 20 * fill_cost + 200;

  logic clk = 1'b0;
  logic rst;
  logic lookup_valid;
  logic [addr_width-1:0] lookup_addr;
  logic lookup_ready;
  logic resp_valid;
  logic resp_hit;
  line_t resp_data;
  logic fill_valid;
  logic [addr_width-1:0] fill_addr;
  line_t fill_data;
  logic fill_ready;
  logic evict_valid;
  logic [addr_width-1:0] evict_addr;
  logic invalidate;

  // cache state as the tests expect it
  logic m_valid [sets][ways];
  logic m_nru [sets][ways];
  tag_t m_tag [sets][ways];
  line_t m_line [sets][ways];

  string cur_test;
  int errors;
  int test_err_start;
  int tests_run;
  int tests_failed;
  logic [addr_width-1:0] filled_q [$];

  always #4 clk = ~clk;

  icache_store i_dut (
    .clk          (clk),
    .rst          (rst),
    .lookup_valid (lookup_valid),
    .lookup_addr  (lookup_addr),
    .lookup_ready (lookup_ready),
    .resp_valid   (resp_valid),
    .resp_hit     (resp_hit),
    .resp_data    (resp_data),
    .fill_valid   (fill_valid),
    .fill_addr    (fill_addr),
    .fill_data    (fill_data),
    .fill_ready   (fill_ready),
    .evict_valid  (evict_valid),
    .evict_addr   (evict_addr),
    .invalidate   (invalidate)
  );

  function automatic logic [addr_width-1:0] line_addr(input tag_t tag, input index_t idx);
    return {tag, idx, {offset_width{1'b0}}};
  endfunction

  function automatic void clear_model();
    for (int s = 0; s < sets; s++) begin
      for (int w = 0; w < ways; w++) begin
        m_valid[s][w] = 1'b0;
        m_nru[s][w] = 1'b0;
      end
    end
  endfunction

  function automatic void model_lookup(input logic [addr_width-1:0] addr,
                                       output logic hit, output line_t data);
    index_t idx;
    tag_t tag;
    idx = addr[offset_width +: index_width];
    tag = addr[addr_width-1 -: tag_width];
    hit = 1'b0;
    data = '0;
    for (int w = 0; w < ways; w++) begin
      if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
        hit = 1'b1;
        data = m_line[idx][w];
        m_nru[idx][w] = 1'b1;
      end
    end
  endfunction

  // resident tag, then lowest invalid, then lowest nru clear, else way 0
  function automatic void model_fill(input logic [addr_width-1:0] addr, input line_t data,
                                     output logic evict, output logic [addr_width-1:0] ev_addr);
    index_t idx;
    tag_t tag;
    int victim;
    idx = addr[offset_width +: index_width];
    tag = addr[addr_width-1 -: tag_width];
    victim = -1;
    evict = 1'b0;
    ev_addr = '0;
    for (int w = 0; w < ways; w++) begin
      if (victim < 0 && m_valid[idx][w] && m_tag[idx][w] == tag) begin
        victim = w;
      end
    end
    for (int w = 0; w < ways; w++) begin
      if (victim < 0 && !m_valid[idx][w]) begin
        victim = w;
      end
    end
    if (victim < 0) begin
      evict = 1'b1;
      for (int w = 0; w < ways; w++) begin
        if (victim < 0 && !m_nru[idx][w]) begin
          victim = w;
        end
      end
      if (victim < 0) begin
        victim = 0;
        for (int w = 1; w < ways; w++) begin
          m_nru[idx][w] = 1'b0;
        end
      end
      ev_addr = line_addr(m_tag[idx][victim], idx);
    end
    m_valid[idx][victim] = 1'b1;
    m_nru[idx][victim] = 1'b1;
    m_tag[idx][victim] = tag;
    m_line[idx][victim] = data;
  endfunction

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("FAIL %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
    errors++;
  endtask

  task automatic report_error(input string msg);
    $display("ERROR %s: %s", cur_test, msg);
    errors++;
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err_start = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors == test_err_start) begin
      $display("test %s passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, errors - test_err_start);
    end
  endtask

  // returns just after the accepting edge
  task automatic send_lookup(input logic [addr_width-1:0] addr);
    int cnt;
    cnt = 0;
    @(posedge clk);
    lookup_valid <= 1'b1;
    lookup_addr <= addr;
    @(negedge clk);
    while (!lookup_ready && cnt < accept_limit) begin
      @(negedge clk);
      cnt++;
    end
    if (!lookup_ready) begin
      report_error("lookup was never accepted");
    end
    @(posedge clk);
    lookup_valid <= 1'b0;
  endtask

  task automatic send_fill(input logic [addr_width-1:0] addr, input line_t data);
    int cnt;
    cnt = 0;
    @(posedge clk);
    fill_valid <= 1'b1;
    fill_addr <= addr;
    fill_data <= data;
    @(negedge clk);
    while (!fill_ready && cnt < accept_limit) begin
      @(negedge clk);
      cnt++;
    end
    if (!fill_ready) begin
      report_error("fill was never accepted");
    end
    @(posedge clk);
    fill_valid <= 1'b0;
  endtask

  // counts edges from acceptance to resp_valid
  task automatic wait_resp(output int lat, output logic got);
    lat = 0;
    @(negedge clk);
    while (!resp_valid && lat < resp_limit) begin
      @(posedge clk);
      lat++;
      @(negedge clk);
    end
    got = resp_valid;
  endtask

  task automatic check_resp(input logic got, input int lat, input logic exp_hit,
                            input line_t exp_data);
    if (!got) begin
      report_error("no response to a lookup");
    end else begin
      if (lat != 2) begin
        report_mismatch("response latency", 2, lat);
      end
      if (resp_hit !== exp_hit) begin
        report_mismatch("resp_hit", exp_hit, resp_hit);
      end
      if (exp_hit && resp_data !== exp_data) begin
        report_mismatch("resp_data", exp_data, resp_data);
      end
    end
  endtask

  task automatic do_lookup(input logic [addr_width-1:0] addr);
    logic exp_hit;
    line_t exp_data;
    int lat;
    logic got;
    model_lookup(addr, exp_hit, exp_data);
    send_lookup(addr);
    wait_resp(lat, got);
    check_resp(got, lat, exp_hit, exp_data);
  endtask

  task automatic do_fill(input logic [addr_width-1:0] addr, input line_t data);
    logic exp_evict;
    logic [addr_width-1:0] exp_eaddr;
    logic [addr_width-1:0] got_eaddr;
    int n_evict;
    int cyc;
    logic done;
    model_fill(addr, data, exp_evict, exp_eaddr);
    send_fill(addr, data);
    n_evict = 0;
    cyc = 0;
    done = 1'b0;
    got_eaddr = '0;
    while (!done) begin
      @(negedge clk);
      if (evict_valid) begin
        n_evict++;
        got_eaddr = evict_addr;
      end
      if (fill_ready || cyc == fill_limit) begin
        done = 1'b1;
      end else begin
        @(posedge clk);
        cyc++;
      end
    end
    if (!fill_ready) begin
      report_error("fill_ready did not return after a fill");
    end else if (cyc != 3) begin
      report_mismatch("fill busy cycles", 3, cyc);
    end
    if (n_evict != int'(exp_evict)) begin
      report_mismatch("evict_valid pulses", exp_evict, n_evict);
    end
    if (exp_evict && got_eaddr !== exp_eaddr) begin
      report_mismatch("evict_addr", exp_eaddr, got_eaddr);
    end
  endtask

  task automatic test_reset_sweep();
    int cnt;
    start_test("reset_sweep");
    cnt = 0;
    @(negedge clk);
    if (lookup_ready || fill_ready) begin
      report_error("ready high at the start of the clearing sweep");
    end
    while (!(lookup_ready && fill_ready) && cnt < accept_limit) begin
      @(posedge clk);
      cnt++;
      @(negedge clk);
    end
    if (!(lookup_ready && fill_ready)) begin
      report_error("ready never rose after reset");
    end else if (cnt < sets) begin
      report_mismatch("sweep cycles", sets, cnt);
    end
    for (int s = 0; s < sets; s++) begin
      do_lookup(line_addr(tag_t'($urandom), index_t'(s)));
    end
    finish_test();
  endtask

  task automatic test_fill_lookup();
    logic [addr_width-1:0] addr;
    start_test("fill_lookup");
    for (int i = 0; i < 8; i++) begin
      addr = line_addr(tag_t'($urandom), index_t'($urandom_range(0, 31)));
      do_fill(addr, {$urandom, $urandom});
      filled_q.push_back(addr);
    end
    foreach (filled_q[i]) begin
      do_lookup(filled_q[i] | ($urandom & 32'h7));
    end
    finish_test();
  endtask

  task automatic test_back_to_back();
    logic [addr_width-1:0] addrs [8];
    logic exp_hit [8];
    line_t exp_data [8];
    int resp_cyc [$];
    logic got_hit [$];
    line_t got_data [$];
    start_test("back_to_back");
    for (int i = 0; i < 8; i++) begin
      if (i % 2 == 0) begin
        addrs[i] = filled_q[$urandom_range(0, filled_q.size() - 1)];
      end else begin
        addrs[i] = line_addr(tag_t'($urandom), index_t'($urandom_range(0, 31)));
      end
      model_lookup(addrs[i], exp_hit[i], exp_data[i]);
    end
    for (int c = 0; c < 8 + resp_limit; c++) begin
      @(posedge clk);
      lookup_valid <= (c < 8);
      if (c < 8) begin
        lookup_addr <= addrs[c];
      end
      @(negedge clk);
      if (c < 8 && !lookup_ready) begin
        report_error("lookup_ready dropped during back-to-back lookups");
      end
      if (resp_valid) begin
        resp_cyc.push_back(c);
        got_hit.push_back(resp_hit);
        got_data.push_back(resp_data);
      end
    end
    if (resp_cyc.size() != 8) begin
      report_mismatch("response count", 8, resp_cyc.size());
    end else begin
      for (int j = 0; j < 8; j++) begin
        // lookup j is accepted one edge after it is driven
        if (resp_cyc[j] != j + 3) begin
          report_mismatch("response cycle", j + 3, resp_cyc[j]);
        end
        if (got_hit[j] !== exp_hit[j]) begin
          report_mismatch("resp_hit", exp_hit[j], got_hit[j]);
        end
        if (exp_hit[j] && got_data[j] !== exp_data[j]) begin
          report_mismatch("resp_data", exp_data[j], got_data[j]);
        end
      end
    end
    finish_test();
  endtask

  task automatic test_replacement();
    index_t idx;
    tag_t base;
    start_test("replacement");
    idx = index_t'($urandom_range(32, 63));
    base = tag_t'($urandom);
    for (int i = 0; i < 4; i++) begin
      do_fill(line_addr(base + tag_t'(i), idx), {$urandom, $urandom});
      filled_q.push_back(line_addr(base + tag_t'(i), idx));
    end
    do_lookup(line_addr(base + tag_t'(1), idx));
    // every nru bit set here, so way 0 goes
    do_fill(line_addr(base + tag_t'(4), idx), {$urandom, $urandom});
    // way 1 marked used again, so way 2 goes next
    do_lookup(line_addr(base + tag_t'(1), idx));
    do_fill(line_addr(base + tag_t'(5), idx), {$urandom, $urandom});
    filled_q.push_back(line_addr(base + tag_t'(4), idx));
    filled_q.push_back(line_addr(base + tag_t'(5), idx));
    // tag already resident so it is overwritten in place
    do_fill(line_addr(base + tag_t'(1), idx), {$urandom, $urandom});
    do_lookup(line_addr(base + tag_t'(1), idx));
    do_lookup(line_addr(base, idx));
    finish_test();
  endtask

  task automatic test_invalidate();
    logic exp_hit;
    line_t exp_data;
    int lat;
    logic got;
    int cnt;
    start_test("invalidate");
    model_lookup(filled_q[filled_q.size() - 1], exp_hit, exp_data);
    send_lookup(filled_q[filled_q.size() - 1]);
    invalidate <= 1'b1;
    fork
      begin
        @(posedge clk);
        invalidate <= 1'b0;
      end
      wait_resp(lat, got);
    join
    check_resp(got, lat, exp_hit, exp_data);
    clear_model();
    cnt = 0;
    while (!lookup_ready && cnt < accept_limit) begin
      @(posedge clk);
      cnt++;
      @(negedge clk);
    end
    if (!lookup_ready) begin
      report_error("lookup_ready never rose after invalidate");
    end
    foreach (filled_q[i]) begin
      do_lookup(filled_q[i]);
    end
    finish_test();
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles in test %s", watchdog_cycles, cur_test);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    void'($urandom(64));
    rst = 1'b1;
    lookup_valid = 1'b0;
    lookup_addr = '0;
    fill_valid = 1'b0;
    fill_addr = '0;
    fill_data = '0;
    invalidate = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    cur_test = "reset";
    clear_model();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    test_reset_sweep();
    test_fill_lookup();
    test_back_to_back();
    test_replacement();
    test_invalidate();
    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* icache_store.f */
hw/icache_cfg_pkg.sv
hw/icache_types_pkg.sv
hw/ic_ram.sv
hw/ic_req_stage.sv
hw/ic_way.sv
hw/ic_way_merge.sv
hw/icache_store.sv
testbench/icache_store_tb.sv

/* Bender.yml */
package:
  name: icache_store

sources:
  - hw/icache_cfg_pkg.sv
  - hw/icache_types_pkg.sv
  - hw/ic_ram.sv
  - hw/ic_req_stage.sv
  - hw/ic_way.sv
  - hw/ic_way_merge.sv
  - hw/icache_store.sv
  - target: test
    files:
      - testbench/icache_store_tb.sv
